// File: sources.f
exec_pkg.sv
alu.sv
alu_unit.sv
mult_pipe.sv
cdb_arbiter.sv
exec_units.sv
exec_units_chk.sv
tb_clk_gen.sv
tb_exec_units.sv

// File: Bender.yml
package:
  name: exec_units

sources:
  - files:
      - exec_pkg.sv
      - alu.sv
      - alu_unit.sv
      - mult_pipe.sv
      - cdb_arbiter.sv
      - exec_units.sv
  - target: test
    files:
      - exec_units_chk.sv
      - tb_clk_gen.sv
      - tb_exec_units.sv

// File: tb_exec_units.sv
`timescale 1ns/1ps

module tb_exec_units
    import exec_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;   // tests need roughly 460 cycles
    localparam int SEED           = 32'h0948_29cd;

    logic       clock;
    logic       rst_n;
    logic       squash;
    logic       alu_valid;
    inst_t      alu_inst;
    addr_t      alu_pc;
    data_t      alu_op1, alu_op2;
    alu_func_t  alu_func;
    opa_sel_t   alu_opa_select;
    opb_sel_t   alu_opb_select;
    logic       alu_cond_branch, alu_uncond_branch;
    robn_t      alu_robn;
    prn_t       alu_dest_prn;
    logic       alu_ready;
    logic       mult_valid;
    mult_func_t mult_func;
    data_t      mult_rs1, mult_rs2;
    robn_t      mult_robn;
    prn_t       mult_dest_prn;
    logic       mult_ready;
    logic       cdb_valid;
    prn_t       cdb_dest_prn;
    robn_t      cdb_robn;
    data_t      cdb_value;
    logic       rob_branch_valid, rob_branch_taken;
    data_t      rob_target;
    robn_t      rob_robn;
    int         cycle;

    tb_clk_gen clk_gen_i (.clock(clock));

    exec_units dut_i (.*);

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic data_t operand_a(input opa_sel_t sel, input data_t rs1, input addr_t pc);
        case (sel)
            OPA_IS_RS1: return rs1;
            OPA_IS_PC:  return pc;
            default:    return '0;
        endcase
    endfunction

    function automatic data_t operand_b(input opb_sel_t sel, input data_t rs2, input inst_t inst);
        case (sel)
            OPB_IS_I_IMM: return imm_i(inst);
            OPB_IS_S_IMM: return imm_s(inst);
            OPB_IS_B_IMM: return imm_b(inst);
            OPB_IS_U_IMM: return imm_u(inst);
            OPB_IS_J_IMM: return imm_j(inst);
            default:      return rs2;
        endcase
    endfunction

    function automatic data_t alu_model(input alu_func_t f, input data_t a, input data_t b);
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SRL:  return a >> b[4:0];
            ALU_SLL:  return a << b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input data_t a, input data_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return !($signed(a) < $signed(b));
            3'b110:  return a < b;
            3'b111:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    // 64-bit product with the low word for MUL and the high word otherwise
    function automatic data_t mult_model(input mult_func_t f, input data_t a, input data_t b);
        longint          sa, sb;
        longint unsigned ua, ub, prod;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = a;
        ub = b;
        case (f)
            MULT_MUL, MULT_MULH: prod = sa * sb;
            MULT_MULHSU:         prod = sa * longint'(ub);
            default:             prod = ua * ub;
        endcase
        return (f == MULT_MUL) ? prod[31:0] : prod[63:32];
    endfunction

    task automatic compare_word(input string name, input data_t got, input data_t exp);
        assert (got === exp) else begin
            $display("error: %s expected %h got %h", name, exp, got);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            $display("Simulation FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic drive_alu(input inst_t inst, input addr_t pc, input data_t a, input data_t b,
                             input alu_func_t f, input opa_sel_t sa, input opb_sel_t sb,
                             input logic cond, input logic uncond, input robn_t robn,
                             input prn_t prn);
        alu_valid         <= 1'b1;
        alu_inst          <= inst;
        alu_pc            <= pc;
        alu_op1           <= a;
        alu_op2           <= b;
        alu_func          <= f;
        alu_opa_select    <= sa;
        alu_opb_select    <= sb;
        alu_cond_branch   <= cond;
        alu_uncond_branch <= uncond;
        alu_robn          <= robn;
        alu_dest_prn      <= prn;
    endtask

    task automatic drive_mult(input mult_func_t f, input data_t a, input data_t b,
                              input robn_t robn, input prn_t prn);
        mult_valid    <= 1'b1;
        mult_func     <= f;
        mult_rs1      <= a;
        mult_rs2      <= b;
        mult_robn     <= robn;
        mult_dest_prn <= prn;
    endtask

    // waits for the next broadcast and checks value and tags
    task automatic expect_cdb(input data_t value, input robn_t robn, input prn_t prn);
        @(negedge clock);
        while (!cdb_valid) @(negedge clock);
        compare_word("cdb_value", cdb_value, value);
        compare_word("cdb_robn", cdb_robn, robn);
        compare_word("cdb_dest_prn", cdb_dest_prn, prn);
    endtask

    task automatic alu_ops();
        inst_t inst;
        addr_t pc;
        data_t a, b, opa, opb;
        robn_t robn;
        prn_t  prn;
        int    f, sa, sb;
        for (f = 0; f < 10; f++) begin
            for (sa = 0; sa < 3; sa++) begin
                for (sb = 0; sb < 6; sb++) begin
                    inst = $urandom();
                    pc   = $urandom() & ~32'h3;
                    a    = $urandom();
                    b    = $urandom();
                    robn = robn_t'($urandom());
                    prn  = prn_t'($urandom());
                    opa  = operand_a(opa_sel_t'(sa), a, pc);
                    opb  = operand_b(opb_sel_t'(sb), b, inst);
                    @(posedge clock);
                    drive_alu(inst, pc, a, b, alu_func_t'(f), opa_sel_t'(sa), opb_sel_t'(sb),
                              1'b0, 1'b0, robn, prn);
                    @(posedge clock);
                    alu_valid <= 1'b0;
                    expect_cdb(alu_model(alu_func_t'(f), opa, opb), robn, prn);
                    require(!rob_branch_valid, "rob_branch_valid rose for a non-branch item");
                end
            end
        end
    endtask

    task automatic branches();
        logic [2:0] f3_list [6];
        inst_t      inst;
        addr_t      pc;
        data_t      a, b, target;
        robn_t      robn;
        int         i, c;
        f3_list = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (i = 0; i < 6; i++) begin
            for (c = 0; c < 3; c++) begin
                a = $urandom();
                b = (c == 0) ? a : $urandom();
                if (c == 1) begin
                    a[XLEN-1] = 1'b1;   // signed less, unsigned greater
                    b[XLEN-1] = 1'b0;
                end else if (c == 2) begin
                    a[XLEN-1] = 1'b0;   // unsigned less, signed greater
                    b[XLEN-1] = 1'b1;
                end
                inst         = $urandom();
                inst[14:12]  = f3_list[i];
                pc           = $urandom() & ~32'h3;
                robn         = robn_t'($urandom());
                target       = pc + imm_b(inst);
                @(posedge clock);
                drive_alu(inst, pc, a, b, ALU_ADD, OPA_IS_PC, OPB_IS_B_IMM, 1'b1, 1'b0, robn, 6'd7);
                @(posedge clock);
                alu_valid <= 1'b0;
                expect_cdb(target, robn, 6'd7);
                require(rob_branch_valid, "rob_branch_valid stayed low for a conditional branch");
                compare_word("rob_branch_taken", rob_branch_taken, branch_model(f3_list[i], a, b));
                compare_word("rob_target", rob_target, target);
                compare_word("rob_robn", rob_robn, robn);
            end
        end
        // jal style jump that is always taken
        inst   = $urandom();
        pc     = $urandom() & ~32'h3;
        target = pc + imm_j(inst);
        @(posedge clock);
        drive_alu(inst, pc, $urandom(), $urandom(), ALU_ADD, OPA_IS_PC, OPB_IS_J_IMM,
                  1'b0, 1'b1, 5'd9, 6'd9);
        @(posedge clock);
        alu_valid <= 1'b0;
        expect_cdb(target, 5'd9, 6'd9);
        require(!rob_branch_valid, "rob_branch_valid rose for an unconditional jump");
        compare_word("rob_branch_taken", rob_branch_taken, 1'b1);
        compare_word("rob_target", rob_target, target);
    endtask

    task automatic mult_stream();
        mult_func_t fq[$];
        data_t      aq[$], bq[$];
        int         exp_cycle[$];
        data_t      a, b;
        int         f, c, idx, got;
        for (f = 0; f < 4; f++) begin
            for (c = 0; c < 4; c++) begin
                a = $urandom();
                b = $urandom();
                if (c == 1) begin
                    a = 32'h8000_0000;  // most negative times -1
                    b = 32'hffff_ffff;
                end else if (c == 2) begin
                    a = 32'hffff_ffff;
                    b = 32'hffff_ffff;
                end else if (c == 3) begin
                    a = 32'h7fff_ffff;
                    b = 32'h8000_0000;
                end
                fq.push_back(mult_func_t'(f));
                aq.push_back(a);
                bq.push_back(b);
            end
        end
        idx = 0;
        got = 0;
        while (got < fq.size()) begin
            @(posedge clock);
            if (idx < fq.size()) begin
                drive_mult(fq[idx], aq[idx], bq[idx], robn_t'(idx), prn_t'(idx + 8));
            end else begin
                mult_valid <= 1'b0;
            end
            @(negedge clock);
            if (idx < fq.size()) begin
                require(mult_ready, "mult_ready was low in a stream that never stalls");
                exp_cycle.push_back(cycle + MULT_STAGES);   // accepted on the next edge
                idx++;
            end
            if (cdb_valid) begin
                compare_word("cdb_value", cdb_value, mult_model(fq[got], aq[got], bq[got]));
                compare_word("cdb_robn", cdb_robn, robn_t'(got));
                compare_word("cdb_dest_prn", cdb_dest_prn, prn_t'(got + 8));
                compare_word("cdb_valid cycle", cycle, exp_cycle[got]);
                got++;
            end
        end
        repeat (2) begin
            @(negedge clock);
            require(!cdb_valid, "cdb_valid rose with no item left in flight");
        end
    endtask

    // ALU result becomes ready in the same cycle as a multiply
    task automatic contention();
        data_t a, b;
        int    first;
        a = $urandom();
        b = $urandom();
        @(posedge clock);
        drive_mult(MULT_MUL, a, b, 5'd3, 6'd30);
        @(negedge clock);
        require(mult_ready, "mult_ready was low with the multiplier empty");
        @(posedge clock);
        mult_valid <= 1'b0;
        repeat (MULT_STAGES - 2) @(posedge clock);
        drive_alu($urandom(), 32'h0, a, b, ALU_ADD, OPA_IS_RS1, OPB_IS_RS2, 1'b0, 1'b0,
                  5'd4, 6'd31);
        @(negedge clock);
        require(alu_ready, "alu_ready was low with the ALU unit idle");
        @(posedge clock);
        alu_valid <= 1'b0;
        expect_cdb(mult_model(MULT_MUL, a, b), 5'd3, 6'd30);
        first = cycle;
        require(!alu_ready, "alu_ready stayed high while the ALU result waited");
        expect_cdb(a + b, 5'd4, 6'd31);
        compare_word("ALU broadcast cycle", cycle, first + 1);
        require(alu_ready, "alu_ready stayed low after the ALU result was granted");
        @(negedge clock);
        require(!cdb_valid, "a result appeared on the bus twice");
    endtask

    task automatic squash_flush();
        data_t a, b;
        int    i;
        for (i = 0; i < 3; i++) begin
            @(posedge clock);
            drive_mult(MULT_MULHU, $urandom(), $urandom(), robn_t'(10 + i), prn_t'(40 + i));
        end
        @(posedge clock);
        mult_valid <= 1'b0;
        drive_alu($urandom(), 32'h100, 32'h5, 32'h5, ALU_ADD, OPA_IS_PC, OPB_IS_B_IMM,
                  1'b1, 1'b0, 5'd20, 6'd50);
        @(posedge clock);
        alu_valid <= 1'b0;
        // branch result parks behind the oldest multiply
        @(negedge clock);
        while (alu_ready) @(negedge clock);
        @(posedge clock);
        squash <= 1'b1;
        @(posedge clock);
        squash <= 1'b0;
        repeat (MULT_STAGES + 2) begin
            @(negedge clock);
            require(!cdb_valid, "cdb_valid rose after squash");
            require(!rob_branch_valid, "rob_branch_valid rose after squash");
        end
        require(alu_ready, "alu_ready was low after squash");
        require(mult_ready, "mult_ready was low after squash");
        a = $urandom();
        b = $urandom();
        @(posedge clock);
        drive_mult(MULT_MULH, a, b, 5'd21, 6'd51);
        @(posedge clock);
        mult_valid <= 1'b0;
        expect_cdb(mult_model(MULT_MULH, a, b), 5'd21, 6'd51);
        @(posedge clock);
        drive_alu($urandom(), 32'h0, a, b, ALU_SUB, OPA_IS_RS1, OPB_IS_RS2, 1'b0, 1'b0,
                  5'd22, 6'd52);
        @(posedge clock);
        alu_valid <= 1'b0;
        expect_cdb(a - b, 5'd22, 6'd52);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n             = 1'b0;
        squash            = 1'b0;
        alu_valid         = 1'b0;
        alu_inst          = '0;
        alu_pc            = '0;
        alu_op1           = '0;
        alu_op2           = '0;
        alu_func          = ALU_ADD;
        alu_opa_select    = OPA_IS_RS1;
        alu_opb_select    = OPB_IS_RS2;
        alu_cond_branch   = 1'b0;
        alu_uncond_branch = 1'b0;
        alu_robn          = '0;
        alu_dest_prn      = '0;
        mult_valid        = 1'b0;
        mult_func         = MULT_MUL;
        mult_rs1          = '0;
        mult_rs2          = '0;
        mult_robn         = '0;
        mult_dest_prn     = '0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        alu_ops();
        branches();
        mult_stream();
        contention();
        squash_flush();
        @(posedge clock);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clock
);

    localparam realtime HALF_PERIOD = 2.0;  // 4 ns period

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

endmodule

// File: exec_units_chk.sv
`timescale 1ns/1ps

module exec_units_chk
    import exec_pkg::*;
(
    input logic  clock,
    input logic  rst_n,
    input logic  alu_grant,
    input logic  mult_grant,
    input logic  alu_done,
    input logic  mult_done,
    input logic  mult_ready,
    input logic  cdb_valid,
    input data_t alu_result,
    input logic  alu_take,
    input logic  alu_is_cond,
    input robn_t alu_out_robn,
    input prn_t  alu_out_dest_prn
);

    one_grant: assert property (@(posedge clock) !(alu_grant && mult_grant))
        else $error("ALU and multiplier were granted the bus in the same cycle");

    quiet_in_reset: assert property (@(posedge clock) !rst_n |-> !cdb_valid)
        else $error("cdb_valid was high during reset");

    // a waiting ALU result keeps its value and tags until it leaves
    alu_hold: assert property (@(posedge clock) disable iff (!rst_n)
        alu_done && !alu_grant |=> $stable(alu_result) && $stable(alu_take)
            && $stable(alu_is_cond) && $stable(alu_out_robn) && $stable(alu_out_dest_prn))
        else $error("held ALU result changed before its grant");

    mult_stall: assert property (@(posedge clock) disable iff (!rst_n)
        mult_ready == !(mult_done && !mult_grant))
        else $error("mult_ready does not match the multiplier stall condition");

endmodule

bind exec_units exec_units_chk chk_i (.*);

// File: exec_units.sv
`timescale 1ns/1ps

module exec_units
    import exec_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       squash,
    // alu issue
    input  logic       alu_valid,
    input  inst_t      alu_inst,
    input  addr_t      alu_pc,
    input  data_t      alu_op1,
    input  data_t      alu_op2,
    input  alu_func_t  alu_func,
    input  opa_sel_t   alu_opa_select,
    input  opb_sel_t   alu_opb_select,
    input  logic       alu_cond_branch,
    input  logic       alu_uncond_branch,
    input  robn_t      alu_robn,
    input  prn_t       alu_dest_prn,
    output logic       alu_ready,
    // multiplier issue
    input  logic       mult_valid,
    input  mult_func_t mult_func,
    input  data_t      mult_rs1,
    input  data_t      mult_rs2,
    input  robn_t      mult_robn,
    input  prn_t       mult_dest_prn,
    output logic       mult_ready,
    // common data bus
    output logic       cdb_valid,
    output prn_t       cdb_dest_prn,
    output robn_t      cdb_robn,
    output data_t      cdb_value,
    // branch report
    output logic       rob_branch_valid,
    output logic       rob_branch_taken,
    output data_t      rob_target,
    output robn_t      rob_robn
);

    logic  alu_done, mult_done;
    logic  alu_grant, mult_grant;
    data_t alu_result, mult_result;
    robn_t alu_out_robn, mult_out_robn;
    prn_t  alu_out_dest_prn, mult_out_dest_prn;
    logic  alu_take, alu_is_cond;

    alu_unit alu_unit_i (
        .clock, .rst_n, .squash,
        .alu_valid, .alu_inst, .alu_pc, .alu_op1, .alu_op2, .alu_func,
        .alu_opa_select, .alu_opb_select, .alu_cond_branch, .alu_uncond_branch,
        .alu_robn, .alu_dest_prn, .alu_grant,
        .alu_ready, .alu_done, .alu_result, .alu_take, .alu_is_cond,
        .alu_out_robn, .alu_out_dest_prn
    );

    mult_pipe mult_pipe_i (
        .clock, .rst_n, .squash,
        .mult_valid, .mult_func, .mult_rs1, .mult_rs2, .mult_robn, .mult_dest_prn,
        .mult_grant,
        .mult_ready, .mult_done, .mult_result, .mult_out_robn, .mult_out_dest_prn
    );

    cdb_arbiter cdb_arbiter_i (
        .alu_done, .mult_done, .alu_result, .mult_result,
        .alu_out_robn, .mult_out_robn, .alu_out_dest_prn, .mult_out_dest_prn,
        .alu_take, .alu_is_cond,
        .alu_grant, .mult_grant,
        .cdb_valid, .cdb_value, .cdb_robn, .cdb_dest_prn,
        .rob_branch_valid, .rob_branch_taken, .rob_target, .rob_robn
    );

endmodule

// File: cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter
    import exec_pkg::*;
(
    input  logic  alu_done,
    input  logic  mult_done,
    input  data_t alu_result,
    input  data_t mult_result,
    input  robn_t alu_out_robn,
    input  robn_t mult_out_robn,
    input  prn_t  alu_out_dest_prn,
    input  prn_t  mult_out_dest_prn,
    input  logic  alu_take,
    input  logic  alu_is_cond,
    output logic  alu_grant,
    output logic  mult_grant,
    output logic  cdb_valid,
    output data_t cdb_value,
    output robn_t cdb_robn,
    output prn_t  cdb_dest_prn,
    output logic  rob_branch_valid,
    output logic  rob_branch_taken,
    output data_t rob_target,
    output robn_t rob_robn
);

    // multiplier first so its pipe never backs up
    assign mult_grant = mult_done;
    assign alu_grant  = alu_done && !mult_done;
    assign cdb_valid  = mult_grant || alu_grant;

    always_comb begin
        if (mult_grant) begin
            cdb_value    = mult_result;
            cdb_robn     = mult_out_robn;
            cdb_dest_prn = mult_out_dest_prn;
        end else begin
            cdb_value    = alu_result;
            cdb_robn     = alu_out_robn;
            cdb_dest_prn = alu_out_dest_prn;
        end
    end

    // report to rob rides along with the alu broadcast
    assign rob_branch_valid = alu_grant && alu_is_cond;
    assign rob_branch_taken = alu_take;
    assign rob_target       = alu_result;   // pc + offset for branches
    assign rob_robn         = alu_out_robn;

endmodule

// File: mult_pipe.sv
`timescale 1ns/1ps

module mult_pipe
    import exec_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       squash,
    input  logic       mult_valid,
    input  mult_func_t mult_func,
    input  data_t      mult_rs1,
    input  data_t      mult_rs2,
    input  robn_t      mult_robn,
    input  prn_t       mult_dest_prn,
    input  logic       mult_grant,
    output logic       mult_ready,
    output logic       mult_done,
    output data_t      mult_result,
    output robn_t      mult_out_robn,
    output prn_t       mult_out_dest_prn
);

    logic       valid_q  [MULT_STAGES];
    mult_func_t func_q   [MULT_STAGES];
    robn_t      robn_q   [MULT_STAGES];
    prn_t       prn_q    [MULT_STAGES];
    prod_t      mcand_q  [MULT_STAGES-1];   // last stage needs no operands
    prod_t      mplier_q [MULT_STAGES-1];
    prod_t      sum_q    [MULT_STAGES];
    prod_t      sum_nxt  [MULT_STAGES];

    prod_t mcand_in;
    prod_t mplier_in;
    logic  sign_a;
    logic  sign_b;
    logic  stall;

    // partial product of slice k shifted into place
    function automatic prod_t partial(input prod_t mcand, input prod_t mplier, input int k);
        prod_t slice;
        slice = prod_t'(mplier[k*SLICE_W +: SLICE_W]);
        return (mcand * slice) << (k * SLICE_W);
    endfunction

    assign sign_a    = (mult_func != MULT_MULHU);
    assign sign_b    = (mult_func == MULT_MUL) || (mult_func == MULT_MULH);
    assign mcand_in  = {{XLEN{sign_a & mult_rs1[XLEN-1]}}, mult_rs1};
    assign mplier_in = {{XLEN{sign_b & mult_rs2[XLEN-1]}}, mult_rs2};

    always_comb begin
        sum_nxt[0] = partial(mcand_in, mplier_in, 0);
        for (int k = 1; k < MULT_STAGES; k++) begin
            sum_nxt[k] = sum_q[k-1] + partial(mcand_q[k-1], mplier_q[k-1], k);
        end
    end

    // whole pipe freezes while the tail waits for the bus
    assign stall      = valid_q[MULT_STAGES-1] && !mult_grant;
    assign mult_ready = !stall;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < MULT_STAGES; k++) begin
                valid_q[k] <= 1'b0;
            end
        end else if (squash) begin
            for (int k = 0; k < MULT_STAGES; k++) begin
                valid_q[k] <= 1'b0;
            end
        end else if (!stall) begin
            valid_q[0] <= mult_valid;
            for (int k = 1; k < MULT_STAGES; k++) begin
                valid_q[k] <= valid_q[k-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            func_q[0]   <= mult_func;
            robn_q[0]   <= mult_robn;
            prn_q[0]    <= mult_dest_prn;
            mcand_q[0]  <= mcand_in;
            mplier_q[0] <= mplier_in;
            sum_q[0]    <= sum_nxt[0];
            for (int k = 1; k < MULT_STAGES; k++) begin
                func_q[k] <= func_q[k-1];
                robn_q[k] <= robn_q[k-1];
                prn_q[k]  <= prn_q[k-1];
                sum_q[k]  <= sum_nxt[k];
            end
            for (int k = 1; k < MULT_STAGES - 1; k++) begin
                mcand_q[k]  <= mcand_q[k-1];
                mplier_q[k] <= mplier_q[k-1];
            end
        end
    end

    assign mult_done         = valid_q[MULT_STAGES-1];
    assign mult_out_robn     = robn_q[MULT_STAGES-1];
    assign mult_out_dest_prn = prn_q[MULT_STAGES-1];
    assign mult_result       = (func_q[MULT_STAGES-1] == MULT_MUL) ?
                               sum_q[MULT_STAGES-1][XLEN-1:0] :
                               sum_q[MULT_STAGES-1][2*XLEN-1:XLEN];   // high word

endmodule

// File: alu_unit.sv
`timescale 1ns/1ps

module alu_unit
    import exec_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      squash,
    input  logic      alu_valid,
    input  inst_t     alu_inst,
    input  addr_t     alu_pc,
    input  data_t     alu_op1,
    input  data_t     alu_op2,
    input  alu_func_t alu_func,
    input  opa_sel_t  alu_opa_select,
    input  opb_sel_t  alu_opb_select,
    input  logic      alu_cond_branch,
    input  logic      alu_uncond_branch,
    input  robn_t     alu_robn,
    input  prn_t      alu_dest_prn,
    input  logic      alu_grant,
    output logic      alu_ready,
    output logic      alu_done,
    output data_t     alu_result,
    output logic      alu_take,
    output logic      alu_is_cond,
    output robn_t     alu_out_robn,
    output prn_t      alu_out_dest_prn
);

    data_t opa_mux;
    data_t opb_mux;
    data_t result_comb;
    logic  cond_true;
    logic  take_comb;
    logic  accept;

    always_comb begin
        case (alu_opa_select)
            OPA_IS_RS1:  opa_mux = alu_op1;
            OPA_IS_PC:   opa_mux = alu_pc;
            OPA_IS_ZERO: opa_mux = '0;
            default:     opa_mux = DEAD_OPA;
        endcase
    end

    always_comb begin
        case (alu_opb_select)
            OPB_IS_RS2:   opb_mux = alu_op2;
            OPB_IS_I_IMM: opb_mux = imm_i(alu_inst);
            OPB_IS_S_IMM: opb_mux = imm_s(alu_inst);
            OPB_IS_B_IMM: opb_mux = imm_b(alu_inst);
            OPB_IS_U_IMM: opb_mux = imm_u(alu_inst);
            OPB_IS_J_IMM: opb_mux = imm_j(alu_inst);
            default:      opb_mux = DEAD_OPB;
        endcase
    end

    alu alu_i (
        .opa    (opa_mux),
        .opb    (opb_mux),
        .func   (alu_func),
        .result (result_comb)
    );

    // branch condition always compares rs1 against rs2
    always_comb begin
        case (alu_inst[14:12])
            3'b000:  cond_true = alu_op1 == alu_op2;                    // beq
            3'b001:  cond_true = alu_op1 != alu_op2;                    // bne
            3'b100:  cond_true = $signed(alu_op1) <  $signed(alu_op2);  // blt
            3'b101:  cond_true = $signed(alu_op1) >= $signed(alu_op2);  // bge
            3'b110:  cond_true = alu_op1 <  alu_op2;                    // bltu
            3'b111:  cond_true = alu_op1 >= alu_op2;                    // bgeu
            default: cond_true = 1'b0;
        endcase
    end

    assign take_comb = alu_uncond_branch || (alu_cond_branch && cond_true);

    // free when empty, or when the held result leaves on this edge
    assign alu_ready = !alu_done || alu_grant;
    assign accept    = alu_valid && alu_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            alu_done <= 1'b0;
        end else if (squash) begin
            alu_done <= 1'b0;
        end else if (accept) begin
            alu_done <= 1'b1;
        end else if (alu_grant) begin
            alu_done <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            alu_result       <= result_comb;
            alu_take         <= take_comb;
            alu_is_cond      <= alu_cond_branch;
            alu_out_robn     <= alu_robn;
            alu_out_dest_prn <= alu_dest_prn;
        end
    end

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu
    import exec_pkg::*;
(
    input  data_t     opa,
    input  data_t     opb,
    input  alu_func_t func,
    output data_t     result
);

    logic signed [XLEN-1:0] opa_s;
    logic signed [XLEN-1:0] opb_s;
    logic        [4:0]      shamt;

    assign opa_s = opa;
    assign opb_s = opb;
    assign shamt = opb[4:0];    // rv32 shifts use 5 bits only

    always_comb begin
        case (func)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            ALU_AND:  result = opa & opb;
            ALU_OR:   result = opa | opb;
            ALU_XOR:  result = opa ^ opb;
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, (opa_s < opb_s)};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, (opa < opb)};
            end
            ALU_SRL:  result = opa >> shamt;
            ALU_SLL:  result = opa << shamt;
            ALU_SRA:  result = opa_s >>> shamt;  // keeps sign bit
            default:  result = ALU_FILL;
        endcase
    end

endmodule

// File: exec_pkg.sv
package exec_pkg;

    // widths
    localparam int XLEN        = 32;
    localparam int PRN_W       = 6;
    localparam int ROBN_W      = 5;

    // multiplier depth with one 16-bit slice of the 64-bit multiplier per stage
    localparam int MULT_STAGES = 4;
    localparam int SLICE_W     = (2 * XLEN) / MULT_STAGES;

    typedef logic [XLEN-1:0]   data_t;
    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [31:0]       inst_t;     // funct3 in [14:12]
    typedef logic [PRN_W-1:0]  prn_t;
    typedef logic [ROBN_W-1:0] robn_t;
    typedef logic [2*XLEN-1:0] prod_t;     // full multiplier width

    // fill values for select codes that are not defined
    localparam data_t DEAD_OPA = 32'hdead_face;
    localparam data_t DEAD_OPB = 32'hface_feed;
    localparam data_t ALU_FILL = 32'hface_beec;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_SLT, ALU_SLTU,
        ALU_OR, ALU_XOR, ALU_SRL, ALU_SLL, ALU_SRA
    } alu_func_t;

    typedef enum logic [1:0] {
        MULT_MUL, MULT_MULH, MULT_MULHSU, MULT_MULHU
    } mult_func_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1, OPA_IS_PC, OPA_IS_ZERO
    } opa_sel_t;

    typedef enum logic [2:0] {
        OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM,
        OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM
    } opb_sel_t;

    // sign-extended immediates, one per RV32 format
    function automatic data_t imm_i(input inst_t inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic data_t imm_s(input inst_t inst);
        return {{20{inst[31]}}, inst[31:25], inst[11:7]};
    endfunction

    function automatic data_t imm_b(input inst_t inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic data_t imm_u(input inst_t inst);
        return {inst[31:12], 12'b0};
    endfunction

    function automatic data_t imm_j(input inst_t inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage
